// ==== ooo_pkg.sv ====
`default_nettype none

package ooo_pkg;

    localparam int NUM_REGS = 8;

    typedef enum logic [4:0] {
        OP_ADD  = 5'd0,
        OP_AND  = 5'd1,
        OP_OR   = 5'd2,
        OP_SLL  = 5'd3,
        OP_SRL  = 5'd4,
        OP_SLT  = 5'd5,
        OP_SLTU = 5'd6,
        OP_SRA  = 5'd7,
        OP_SUB  = 5'd8,
        OP_XOR  = 5'd9,
        OP_LUI  = 5'd14,
        OP_LW   = 5'd20,
        OP_SW   = 5'd25,
        OP_NOP  = 5'd31
    } opcode_e;

    typedef logic [2:0] tag_t;      // 0 means value present
    typedef logic [2:0] reg_idx_t;

    typedef struct packed {
        opcode_e     opcode;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        logic [17:0] imm;
    } instr_word_t;

    typedef struct packed {
        opcode_e     op;
        reg_idx_t    rd;
        logic [31:0] value1;
        logic [31:0] value2;
        logic [31:0] imm;
        tag_t        query1;
        tag_t        query2;
    } dispatch_t;

    typedef struct packed {
        logic        valid;
        opcode_e     op;
        tag_t        dest;
        logic [31:0] value1;
        logic [31:0] value2;
        logic [31:0] imm;
    } issue_t;

    typedef struct packed {
        logic        valid;
        tag_t        tag;
        logic [31:0] data;
    } result_t;

    typedef struct packed {
        logic        valid;
        reg_idx_t    rd;
        logic [31:0] data;
    } retire_t;

    function automatic logic is_mem_op(opcode_e op);
        return op == OP_LW || op == OP_SW;
    endfunction

    function automatic logic is_alu_op(opcode_e op);
        return op inside {OP_ADD, OP_AND, OP_OR, OP_SLL, OP_SRL, OP_SLT, OP_SLTU,
                          OP_SRA, OP_SUB, OP_XOR, OP_LUI};
    endfunction

endpackage

`default_nettype wire

// ==== issue_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_decode (
    input  ooo_pkg::instr_word_t instr,
    input  logic                 instr_valid,
    input  ooo_pkg::result_t     alu_result,
    input  ooo_pkg::result_t     mem_result,
    input  logic                 pool_full_alu,
    input  logic                 pool_full_mem,
    input  ooo_pkg::tag_t        alloc_tag,
    input  logic [31:0]          rs1_value,
    input  ooo_pkg::tag_t        rs1_tag,
    input  logic [31:0]          rs2_value,
    input  ooo_pkg::tag_t        rs2_tag,
    output logic                 instr_ready,
    output ooo_pkg::dispatch_t   dispatch,
    output logic                 load,
    output ooo_pkg::reg_idx_t    rs1_idx,
    output ooo_pkg::reg_idx_t    rs2_idx,
    output logic                 new_tag_we,
    output ooo_pkg::reg_idx_t    new_tag_rd,
    output ooo_pkg::tag_t        new_tag
);

    logic          is_alu;
    logic          is_mem;
    logic [31:0]   op1_value;
    logic [31:0]   op2_value;
    ooo_pkg::tag_t op1_query;
    ooo_pkg::tag_t op2_query;

    // Pick up a result broadcast in this very cycle
    function automatic logic [34:0] resolve(ooo_pkg::tag_t tag, logic [31:0] value);
        if (tag != 3'd0 && mem_result.valid && mem_result.tag == tag) begin
            return {3'd0, mem_result.data};
        end
        if (tag != 3'd0 && alu_result.valid && alu_result.tag == tag) begin
            return {3'd0, alu_result.data};
        end
        return {tag, value};
    endfunction

    always_comb begin
        is_alu = ooo_pkg::is_alu_op(instr.opcode);
        is_mem = ooo_pkg::is_mem_op(instr.opcode);
        rs1_idx = (instr.opcode == ooo_pkg::OP_LUI) ? 3'd0 : instr.rs1;
        rs2_idx = instr.rs2;
        {op1_query, op1_value} = resolve(rs1_tag, rs1_value);
        {op2_query, op2_value} = resolve(rs2_tag, rs2_value);

        dispatch.op = instr.opcode;
        dispatch.rd = instr.rd;
        dispatch.imm = {{14{instr.imm[17]}}, instr.imm};   // Load/store offset
        dispatch.value1 = op1_value;
        dispatch.query1 = op1_query;
        if (instr.opcode == ooo_pkg::OP_LUI) begin
            dispatch.value2 = {instr.imm, 14'd0};
            dispatch.query2 = 3'd0;
        end else if (instr.opcode == ooo_pkg::OP_LW) begin
            dispatch.value2 = 32'd0;                     // No second source
            dispatch.query2 = 3'd0;
        end else begin
            dispatch.value2 = op2_value;                 // Store data for SW
            dispatch.query2 = op2_query;
        end

        if (is_mem) begin
            instr_ready = !pool_full_mem;
        end else if (is_alu) begin
            instr_ready = !pool_full_alu;
        end else begin
            instr_ready = !(pool_full_alu && pool_full_mem);   // Dropped word
        end
        load = instr_valid && instr_ready && (is_alu || is_mem);
        new_tag_we = load && instr.opcode != ooo_pkg::OP_SW && instr.rd != 3'd0;
    end

    assign new_tag_rd = dispatch.rd;
    assign new_tag = alloc_tag;

endmodule

`default_nettype wire

// ==== reservation_station.sv ====
`timescale 1ns/1ps
`default_nettype none

module reservation_station #(
    parameter int POOL_DEPTH = 3
) (
    input  logic               clk,
    input  logic               rst,
    input  ooo_pkg::dispatch_t dispatch,
    input  logic               load,
    input  ooo_pkg::result_t   alu_result,
    input  ooo_pkg::result_t   mem_result,
    input  logic               mem_busy,
    output ooo_pkg::tag_t      alloc_tag,
    output logic               pool_full_alu,
    output logic               pool_full_mem,
    output ooo_pkg::issue_t    alu_issue,
    output ooo_pkg::issue_t    mem_issue,
    output logic               empty
);

    localparam int NUM_ENTRIES = 2 * POOL_DEPTH;
    localparam logic [NUM_ENTRIES-1:0] ALU_POOL = {{POOL_DEPTH{1'b0}}, {POOL_DEPTH{1'b1}}};
    localparam logic [NUM_ENTRIES-1:0] MEM_POOL = ~ALU_POOL;

    ooo_pkg::dispatch_t     entry [NUM_ENTRIES];
    logic [NUM_ENTRIES-1:0] busy;
    logic [NUM_ENTRIES-1:0] ready;
    logic [NUM_ENTRIES-1:0] free;
    logic                   running;
    ooo_pkg::tag_t          alu_pick;
    ooo_pkg::tag_t          mem_pick;
    ooo_pkg::result_t       bus [2];

    // Tag of the lowest set bit, 0 when none
    function automatic ooo_pkg::tag_t lowest_tag(logic [NUM_ENTRIES-1:0] mask);
        ooo_pkg::tag_t tag;
        tag = 3'd0;
        for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
            if (mask[i]) begin
                tag = ooo_pkg::tag_t'(i + 1);
            end
        end
        return tag;
    endfunction

    function automatic ooo_pkg::issue_t to_issue(ooo_pkg::dispatch_t e, ooo_pkg::tag_t dest);
        ooo_pkg::issue_t iss;
        iss.valid = 1'b1;
        iss.op = e.op;
        iss.dest = dest;
        iss.value1 = e.value1;
        iss.value2 = e.value2;
        iss.imm = e.imm;
        return iss;
    endfunction

    assign bus[0] = alu_result;
    assign bus[1] = mem_result;   // Later index wins

    // A slot stays locked until its result has left the bus
    always_comb begin
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            ready[i] = busy[i] && entry[i].query1 == 3'd0 && entry[i].query2 == 3'd0;
            free[i] = !busy[i]
                && !(alu_issue.valid && alu_issue.dest == ooo_pkg::tag_t'(i + 1))
                && !(mem_busy && mem_issue.dest == ooo_pkg::tag_t'(i + 1));
        end
    end

    assign alu_pick = lowest_tag(ready & ALU_POOL);
    assign mem_pick = mem_busy ? 3'd0 : lowest_tag(ready & MEM_POOL);
    assign alloc_tag = lowest_tag(free & (ooo_pkg::is_mem_op(dispatch.op) ? MEM_POOL : ALU_POOL));
    assign pool_full_alu = !running || (free & ALU_POOL) == '0;
    assign pool_full_mem = !running || (free & MEM_POOL) == '0;
    assign empty = busy == '0;

    always_ff @(posedge clk) begin
        if (!rst) begin
            busy <= '0;
            running <= 1'b0;
            alu_issue.valid <= 1'b0;
            mem_issue.valid <= 1'b0;
        end else begin
            running <= 1'b1;
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                for (int b = 0; b < 2; b++) begin
                    if (busy[i] && bus[b].valid && entry[i].query1 == bus[b].tag) begin
                        entry[i].value1 <= bus[b].data;
                        entry[i].query1 <= 3'd0;
                    end
                    if (busy[i] && bus[b].valid && entry[i].query2 == bus[b].tag) begin
                        entry[i].value2 <= bus[b].data;
                        entry[i].query2 <= 3'd0;
                    end
                end
            end

            alu_issue.valid <= 1'b0;
            if (alu_pick != 3'd0) begin
                alu_issue <= to_issue(entry[alu_pick - 3'd1], alu_pick);
                busy[alu_pick - 3'd1] <= 1'b0;
            end
            mem_issue.valid <= 1'b0;
            if (mem_pick != 3'd0) begin
                mem_issue <= to_issue(entry[mem_pick - 3'd1], mem_pick);
                busy[mem_pick - 3'd1] <= 1'b0;
            end

            if (load) begin
                busy[alloc_tag - 3'd1] <= 1'b1;
                entry[alloc_tag - 3'd1] <= dispatch;
            end
        end
    end

endmodule

`default_nettype wire

// ==== alu_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_unit (
    input  logic             clk,
    input  logic             rst,
    input  ooo_pkg::issue_t  alu_issue,
    output ooo_pkg::result_t alu_result,
    output logic             alu_idle
);

    logic [31:0] value1;
    logic [31:0] value2;
    logic [31:0] data;

    assign value1 = alu_issue.value1;
    assign value2 = alu_issue.value2;

    always_comb begin
        case (alu_issue.op)
            ooo_pkg::OP_ADD:  data = value1 + value2;
            ooo_pkg::OP_SUB:  data = value1 - value2;
            ooo_pkg::OP_AND:  data = value1 & value2;
            ooo_pkg::OP_OR:   data = value1 | value2;
            ooo_pkg::OP_XOR:  data = value1 ^ value2;
            ooo_pkg::OP_SLL:  data = value1 << value2[4:0];
            ooo_pkg::OP_SRL:  data = value1 >> value2[4:0];
            ooo_pkg::OP_SRA:  data = $signed(value1) >>> value2[4:0];
            ooo_pkg::OP_SLT:  data = {31'd0, $signed(value1) < $signed(value2)};
            ooo_pkg::OP_SLTU: data = {31'd0, value1 < value2};
            ooo_pkg::OP_LUI:  data = value2;                 // Already shifted
            default:          data = 32'd0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            alu_result.valid <= 1'b0;
        end else begin
            alu_result.valid <= alu_issue.valid;
            alu_result.tag <= alu_issue.dest;
            alu_result.data <= data;
        end
    end

    assign alu_idle = !alu_issue.valid && !alu_result.valid;

endmodule

`default_nettype wire

// ==== load_store_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_store_unit (
    input  logic             clk,
    input  logic             rst,
    input  ooo_pkg::issue_t  mem_issue,
    input  logic [31:0]      wb_dat_i,
    input  logic             wb_ack,
    output logic             mem_busy,
    output ooo_pkg::result_t mem_result,
    output logic             wb_cyc,
    output logic             wb_stb,
    output logic             wb_we,
    output logic [31:0]      wb_adr,
    output logic [31:0]      wb_dat_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BUS,
        ST_RESPOND
    } lsu_state_e;

    lsu_state_e  state;
    logic [31:0] eff_addr;

    assign eff_addr = mem_issue.value1 + mem_issue.imm;
    assign mem_busy = mem_issue.valid || state != ST_IDLE;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= ST_IDLE;
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            mem_result.valid <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (mem_issue.valid) begin
                        state <= ST_BUS;
                        wb_cyc <= 1'b1;
                        wb_stb <= 1'b1;
                        wb_we <= mem_issue.op == ooo_pkg::OP_SW;
                        wb_adr <= {2'b00, eff_addr[31:2]};       // Word address
                        wb_dat_o <= mem_issue.value2;
                        mem_result.tag <= mem_issue.dest;
                    end
                end
                ST_BUS: begin
                    if (wb_ack) begin
                        wb_cyc <= 1'b0;
                        wb_stb <= 1'b0;
                        if (wb_we) begin
                            state <= ST_IDLE;                    // Store done
                        end else begin
                            state <= ST_RESPOND;
                            mem_result.valid <= 1'b1;
                            mem_result.data <= wb_dat_i;
                        end
                    end
                end
                default: begin
                    state <= ST_IDLE;
                    mem_result.valid <= 1'b0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== writeback_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module writeback_regfile (
    input  logic              clk,
    input  logic              rst,
    input  ooo_pkg::reg_idx_t rs1_idx,
    input  ooo_pkg::reg_idx_t rs2_idx,
    input  logic              new_tag_we,
    input  ooo_pkg::reg_idx_t new_tag_rd,
    input  ooo_pkg::tag_t     new_tag,
    input  ooo_pkg::result_t  alu_result,
    input  ooo_pkg::result_t  mem_result,
    output logic [31:0]       rs1_value,
    output ooo_pkg::tag_t     rs1_tag,
    output logic [31:0]       rs2_value,
    output ooo_pkg::tag_t     rs2_tag,
    output ooo_pkg::retire_t  retire
);

    logic [31:0]      regs [ooo_pkg::NUM_REGS];
    ooo_pkg::tag_t    tags [ooo_pkg::NUM_REGS];
    ooo_pkg::retire_t alu_wr;
    ooo_pkg::retire_t mem_wr;
    ooo_pkg::retire_t pend;      // ALU write that lost the trace slot

    assign rs1_value = regs[rs1_idx];
    assign rs1_tag = tags[rs1_idx];
    assign rs2_value = regs[rs2_idx];
    assign rs2_tag = tags[rs2_idx];

    // Only the latest writer of a register matches its tag
    always_comb begin
        alu_wr = '0;
        mem_wr = '0;
        for (int r = 1; r < ooo_pkg::NUM_REGS; r++) begin
            if (tags[r] != 3'd0 && alu_result.valid && tags[r] == alu_result.tag) begin
                alu_wr = '{valid: 1'b1, rd: ooo_pkg::reg_idx_t'(r), data: alu_result.data};
            end
            if (tags[r] != 3'd0 && mem_result.valid && tags[r] == mem_result.tag) begin
                mem_wr = '{valid: 1'b1, rd: ooo_pkg::reg_idx_t'(r), data: mem_result.data};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int r = 0; r < ooo_pkg::NUM_REGS; r++) begin
                regs[r] <= 32'd0;
                tags[r] <= 3'd0;
            end
            pend.valid <= 1'b0;
            retire.valid <= 1'b0;
        end else begin
            if (alu_wr.valid) begin
                regs[alu_wr.rd] <= alu_wr.data;
                tags[alu_wr.rd] <= 3'd0;
            end
            if (mem_wr.valid) begin
                regs[mem_wr.rd] <= mem_wr.data;          // Memory bus wins
                tags[mem_wr.rd] <= 3'd0;
            end
            if (new_tag_we) begin
                tags[new_tag_rd] <= new_tag;
            end

            if (mem_wr.valid) begin
                retire <= mem_wr;
                if (alu_wr.valid) begin
                    pend <= alu_wr;
                end
            end else if (pend.valid) begin
                retire <= pend;
                pend <= alu_wr;
            end else begin
                retire <= alu_wr;
            end
        end
    end

endmodule

`default_nettype wire

// ==== ooo_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module ooo_core #(
    parameter int POOL_DEPTH = 3
) (
    input  logic                 clk,
    input  logic                 rst,
    input  ooo_pkg::instr_word_t instr,
    input  logic                 instr_valid,
    input  logic [31:0]          wb_dat_i,
    input  logic                 wb_ack,
    output logic                 instr_ready,
    output logic                 wb_cyc,
    output logic                 wb_stb,
    output logic                 wb_we,
    output logic [31:0]          wb_adr,
    output logic [31:0]          wb_dat_o,
    output ooo_pkg::retire_t     retire,
    output logic                 idle
);

    ooo_pkg::dispatch_t dispatch;
    logic               load;
    ooo_pkg::tag_t      alloc_tag;
    logic               pool_full_alu;
    logic               pool_full_mem;
    ooo_pkg::issue_t    alu_issue;
    ooo_pkg::issue_t    mem_issue;
    ooo_pkg::result_t   alu_result;
    ooo_pkg::result_t   mem_result;
    logic               rs_empty;
    logic               alu_idle;
    logic               mem_busy;
    ooo_pkg::reg_idx_t  rs1_idx;
    ooo_pkg::reg_idx_t  rs2_idx;
    logic [31:0]        rs1_value;
    logic [31:0]        rs2_value;
    ooo_pkg::tag_t      rs1_tag;
    ooo_pkg::tag_t      rs2_tag;
    logic               new_tag_we;
    ooo_pkg::reg_idx_t  new_tag_rd;
    ooo_pkg::tag_t      new_tag;

    issue_decode decode_inst (.*);

    reservation_station #(
        .POOL_DEPTH(POOL_DEPTH)
    ) rs_inst (
        .empty(rs_empty),
        .*
    );

    alu_unit alu_inst (.*);

    load_store_unit lsu_inst (.*);

    writeback_regfile regfile_inst (.*);

    assign idle = rs_empty && alu_idle && !mem_busy;

endmodule

`default_nettype wire

// ==== ooo_core_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module ooo_core_properties #(
    parameter int POOL_DEPTH = 3
) (
    input logic                 clk,
    input logic                 rst,
    input ooo_pkg::instr_word_t instr,
    input logic                 instr_ready,
    input logic                 pool_full_alu,
    input logic                 pool_full_mem,
    input ooo_pkg::issue_t      alu_issue,
    input ooo_pkg::result_t     alu_result,
    input ooo_pkg::result_t     mem_result,
    input logic                 wb_cyc,
    input logic                 wb_stb,
    input logic                 wb_we,
    input logic                 wb_ack,
    input logic [31:0]          wb_adr,
    input logic [31:0]          wb_dat_o,
    input logic [31:0]          wb_dat_i
);

    int   violations = 0;
    logic mem_op;
    logic alu_op;

    assign mem_op = instr.opcode inside {ooo_pkg::OP_LW, ooo_pkg::OP_SW};
    assign alu_op = instr.opcode inside {ooo_pkg::OP_ADD, ooo_pkg::OP_AND, ooo_pkg::OP_OR,
                                         ooo_pkg::OP_SLL, ooo_pkg::OP_SRL, ooo_pkg::OP_SLT,
                                         ooo_pkg::OP_SLTU, ooo_pkg::OP_SRA, ooo_pkg::OP_SUB,
                                         ooo_pkg::OP_XOR, ooo_pkg::OP_LUI};

    stb_in_cyc: assert property (@(posedge clk) disable iff (!rst) wb_stb |-> wb_cyc)
        else begin
            violations++;
            $error("wb_stb high without wb_cyc");
        end

    bus_hold: assert property (@(posedge clk) disable iff (!rst)
        wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr) && $stable(wb_dat_o) && $stable(wb_we))
        else begin
            violations++;
            $error("Wishbone request changed before ack");
        end

    // Load data is broadcast in the cycle after ack
    load_after_ack: assert property (@(posedge clk) disable iff (!rst)
        wb_ack && !wb_we |=> mem_result.valid && mem_result.data == $past(wb_dat_i))
        else begin
            violations++;
            $error("load result not in the cycle after ack");
        end

    alu_latency: assert property (@(posedge clk) disable iff (!rst)
        alu_issue.valid |=> alu_result.valid && alu_result.tag == $past(alu_issue.dest))
        else begin
            violations++;
            $error("alu_result late or with wrong tag");
        end

    ready_when_full: assert property (@(posedge clk) disable iff (!rst)
        (mem_op && pool_full_mem) || (alu_op && pool_full_alu) |-> !instr_ready)
        else begin
            violations++;
            $error("instr_ready high with selected pool full");
        end

endmodule

bind ooo_core ooo_core_properties #(
    .POOL_DEPTH(POOL_DEPTH)
) props_inst (.*);

`default_nettype wire

// ==== tb_ooo_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ooo_core;

    localparam int POOL_DEPTH = 3;
    localparam int TIMEOUT_CYCLES = 2000;       // Longest run is near 400 cycles
    localparam int MEM_WORDS = 64;

    logic                 clk = 1'b0;
    logic                 rst;
    ooo_pkg::instr_word_t instr;
    logic                 instr_valid;
    logic [31:0]          wb_dat_i;
    logic                 wb_ack;
    logic                 instr_ready;
    logic                 wb_cyc;
    logic                 wb_stb;
    logic                 wb_we;
    logic [31:0]          wb_adr;
    logic [31:0]          wb_dat_o;
    ooo_pkg::retire_t     retire;
    logic                 idle;

    integer               seed = 32'h0eb91953;
    int                   cycles = 0;
    int                   ack_wait;
    logic                 in_xfer = 1'b0;
    logic [31:0]          mem [MEM_WORDS];
    logic [31:0]          ref_mem [MEM_WORDS];
    logic [31:0]          ref_regs [ooo_pkg::NUM_REGS];
    logic [31:0]          last_retire [ooo_pkg::NUM_REGS];
    logic [31:0]          exp_val [ooo_pkg::NUM_REGS][64];   // Writes per register in order
    int                   exp_cnt [ooo_pkg::NUM_REGS];
    int                   exp_ptr [ooo_pkg::NUM_REGS];
    ooo_pkg::reg_idx_t    ret_rd;

    ooo_core #(
        .POOL_DEPTH(POOL_DEPTH)
    ) ooo_core_inst (.*);

    always #4 clk = ~clk;

    task automatic stop_failed();
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic value_error(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        stop_failed();
    endtask

    function automatic logic [31:0] fill_word(input int addr);
        return (addr + 1) * 32'h9e3779b9 ^ 32'h5bd1e995;
    endfunction

    // Sequential execution of one instruction
    task automatic model_step(input ooo_pkg::instr_word_t w);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] eff;
        logic        write;
        a = ref_regs[w.rs1];
        b = ref_regs[w.rs2];
        eff = a + {{14{w.imm[17]}}, w.imm};
        res = 32'd0;
        write = 1'b1;
        case (w.opcode)
            ooo_pkg::OP_ADD:  res = a + b;
            ooo_pkg::OP_SUB:  res = a - b;
            ooo_pkg::OP_AND:  res = a & b;
            ooo_pkg::OP_OR:   res = a | b;
            ooo_pkg::OP_XOR:  res = a ^ b;
            ooo_pkg::OP_SLL:  res = a << b[4:0];
            ooo_pkg::OP_SRL:  res = a >> b[4:0];
            ooo_pkg::OP_SRA:  res = $signed(a) >>> b[4:0];
            ooo_pkg::OP_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ooo_pkg::OP_SLTU: res = (a < b) ? 32'd1 : 32'd0;
            ooo_pkg::OP_LUI:  res = {w.imm, 14'd0};
            ooo_pkg::OP_LW:   res = ref_mem[eff[7:2]];
            ooo_pkg::OP_SW: begin
                ref_mem[eff[7:2]] = b;
                write = 1'b0;
            end
            default:          write = 1'b0;          // NOP is dropped
        endcase
        if (write && w.rd != 3'd0) begin
            ref_regs[w.rd] = res;
            exp_val[w.rd][exp_cnt[w.rd]] = res;
            exp_cnt[w.rd]++;
        end
    endtask

    // Called and returns 1 ns after a rising edge
    task automatic send_instr(input ooo_pkg::opcode_e op, input int rd, input int rs1,
                              input int rs2, input int imm);
        ooo_pkg::instr_word_t w;
        w.opcode = op;
        w.rd = rd[2:0];
        w.rs1 = rs1[2:0];
        w.rs2 = rs2[2:0];
        w.imm = imm[17:0];
        model_step(w);
        instr = w;
        instr_valid = 1'b1;
        #1;
        while (!instr_ready) begin
            @(posedge clk);
            #2;
        end
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
    endtask

    task automatic check_drained();
        for (int r = 1; r < ooo_pkg::NUM_REGS; r++) begin
            assert (exp_ptr[r] == exp_cnt[r])
                else value_error($sformatf("last write to r%0d never retired", r));
        end
    endtask

    task automatic wait_idle();
        @(negedge clk);
        while (!idle) begin
            @(negedge clk);
        end
        repeat (3) @(negedge clk);                 // Trailing retire
        check_drained();
        @(posedge clk);
        #1;
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            stop_failed();
        end
    end

    // Wishbone slave, ack after 0 to 3 wait cycles
    always @(posedge clk) begin
        #1;
        if (!rst) begin
            wb_ack = 1'b0;
            in_xfer = 1'b0;
        end else if (wb_ack) begin
            wb_ack = 1'b0;
        end else if (wb_cyc && wb_stb) begin
            if (!in_xfer) begin
                in_xfer = 1'b1;
                ack_wait = $random(seed) & 3;
            end
            if (ack_wait == 0) begin
                wb_ack = 1'b1;
                in_xfer = 1'b0;
                if (wb_we) begin
                    mem[wb_adr[5:0]] = wb_dat_o;
                end else begin
                    wb_dat_i = mem[wb_adr[5:0]];
                end
            end else begin
                ack_wait--;
            end
        end
    end

    // Older writes may be skipped once a newer writer owns the register
    always @(negedge clk) begin
        if (rst && retire.valid) begin
            ret_rd = retire.rd;
            while (exp_ptr[ret_rd] < exp_cnt[ret_rd]
                   && exp_val[ret_rd][exp_ptr[ret_rd]] != retire.data) begin
                exp_ptr[ret_rd]++;
            end
            assert (exp_ptr[ret_rd] < exp_cnt[ret_rd])
                else value_error($sformatf("retire r%0d = 0x%08h matches no pending write",
                                           ret_rd, retire.data));
            exp_ptr[ret_rd]++;
            last_retire[ret_rd] = retire.data;
        end
    end

    always @(negedge clk) begin
        assert (ooo_core_inst.props_inst.violations == 0) else begin
            $display("A bus or handshake property of the core failed");
            stop_failed();
        end
    end

    initial begin
        rst = 1'b0;
        instr = '0;
        instr_valid = 1'b0;
        wb_dat_i = 32'd0;
        wb_ack = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = fill_word(i);
            ref_mem[i] = fill_word(i);
        end
        for (int r = 0; r < ooo_pkg::NUM_REGS; r++) begin
            ref_regs[r] = 32'd0;
            last_retire[r] = 32'd0;
            exp_cnt[r] = 0;
            exp_ptr[r] = 0;
        end

        repeat (4) begin
            @(posedge clk);
            #1;
            assert (!instr_ready && !wb_cyc && !retire.valid)
                else value_error("instr_ready, wb_cyc or retire.valid high during reset");
        end
        rst = 1'b1;
        @(negedge clk);
        assert (idle) else value_error("idle low after reset release");
        @(posedge clk);
        #1;

        for (int k = 1; k < 8; k++) begin
            send_instr(ooo_pkg::OP_LW, k, 0, 0, 4 * k);   // Seed r1 to r7
        end
        wait_idle();

        send_instr(ooo_pkg::OP_ADD, 5, 1, 2, 0);
        send_instr(ooo_pkg::OP_SUB, 6, 3, 4, 0);
        send_instr(ooo_pkg::OP_AND, 7, 1, 3, 0);
        wait_idle();
        send_instr(ooo_pkg::OP_OR, 5, 2, 4, 0);
        send_instr(ooo_pkg::OP_XOR, 6, 1, 4, 0);
        send_instr(ooo_pkg::OP_SLL, 7, 2, 3, 0);
        wait_idle();
        send_instr(ooo_pkg::OP_SRL, 5, 3, 1, 0);
        send_instr(ooo_pkg::OP_SRA, 6, 1, 2, 0);
        send_instr(ooo_pkg::OP_SLT, 7, 4, 1, 0);
        wait_idle();
        send_instr(ooo_pkg::OP_SLTU, 5, 2, 3, 0);
        send_instr(ooo_pkg::OP_LUI, 6, 0, 0, $random(seed));
        send_instr(ooo_pkg::OP_SLT, 7, 1, 4, 0);
        wait_idle();

        // Each one reads the previous result
        send_instr(ooo_pkg::OP_ADD, 5, 1, 2, 0);
        send_instr(ooo_pkg::OP_XOR, 6, 5, 3, 0);
        send_instr(ooo_pkg::OP_SUB, 7, 6, 5, 0);
        send_instr(ooo_pkg::OP_NOP, 1, 1, 1, 0);
        send_instr(ooo_pkg::OP_SRL, 5, 7, 4, 0);
        send_instr(ooo_pkg::OP_SLT, 6, 5, 7, 0);
        send_instr(ooo_pkg::OP_OR, 7, 6, 1, 0);
        send_instr(ooo_pkg::OP_SRA, 4, 7, 2, 0);
        send_instr(ooo_pkg::OP_AND, 3, 4, 7, 0);
        wait_idle();

        send_instr(ooo_pkg::OP_XOR, 2, 1, 3, 0);       // Address for store and load
        send_instr(ooo_pkg::OP_SW, 0, 2, 5, 12);
        send_instr(ooo_pkg::OP_LW, 6, 2, 0, 12);
        send_instr(ooo_pkg::OP_ADD, 7, 6, 1, 0);
        wait_idle();

        for (int k = 0; k < 6; k++) begin
            send_instr(ooo_pkg::OP_SW, 0, 0, k + 1, 4 * (48 + k));
            send_instr(ooo_pkg::OP_LW, 7 - k, 0, 0, 4 * (1 + k));
        end
        wait_idle();

        for (int r = 1; r < ooo_pkg::NUM_REGS; r++) begin
            assert (last_retire[r] == ref_regs[r])
                else value_error($sformatf("r%0d = 0x%08h, expected 0x%08h",
                                           r, last_retire[r], ref_regs[r]));
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            assert (mem[i] == ref_mem[i])
                else value_error($sformatf("mem[%0d] = 0x%08h, expected 0x%08h",
                                           i, mem[i], ref_mem[i]));
        end
        repeat (2) @(negedge clk);
        if (ooo_core_inst.props_inst.violations != 0) begin
            $display("A bus or handshake property of the core failed");
            stop_failed();
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== sources.f ====
ooo_pkg.sv
issue_decode.sv
reservation_station.sv
alu_unit.sv
load_store_unit.sv
writeback_regfile.sv
ooo_core.sv
ooo_core_properties.sv
tb_ooo_core.sv
